// ==== msx_video_pkg.sv ====
// Video output stage shared package: status field layout, crop widths, field types
package msx_video_pkg;

   // ==============================
   // Field types
   // ==============================

   // Aspect choice from the host menu
   typedef enum logic [1:0] {
      ASPECT_ORIGINAL = 2'd0,
      ASPECT_FULL     = 2'd1,
      ASPECT_CUSTOM1  = 2'd2,
      ASPECT_CUSTOM2  = 2'd3
   } aspect_t;

   // Scanline darkening level
   typedef enum logic [1:0] {
      SL_NONE = 2'd0,
      SL_25   = 2'd1,
      SL_50   = 2'd2,
      SL_75   = 2'd3
   } scanline_t;

   // Scaler mode, passed to the scaler unchanged
   typedef enum logic [1:0] {
      SCALE_NORMAL     = 2'd0,
      SCALE_V_INTEGER  = 2'd1,
      SCALE_NARROW_INT = 2'd2,
      SCALE_WIDE_INT   = 2'd3
   } scale_t;

   // ==============================
   // Status word layout
   // ==============================

   // Low bit of each 2-bit field
   localparam int ST_ASPECT   = 1;
   localparam int ST_SCANLINE = 3;
   localparam int ST_SCALE    = 5;
   // Single-bit vertical crop enable
   localparam int ST_VCROP    = 7;

   // ==============================
   // Aspect and size constants
   // ==============================

   localparam logic [11:0] ARX_NORMAL = 12'd400;
   localparam logic [11:0] ARX_WIDE   = 12'd340;
   localparam logic [11:0] ARY_NORMAL = 12'd300;

   localparam int CROP_W = 10;
   localparam int HDMI_W = 12;

endpackage

// ==== video_cfg_if.sv ====
// Decoded video settings carried from the status register to the crop selector
interface video_cfg_if;
   import msx_video_pkg::*;

   // Menu fields, all plain levels
   aspect_t   aspect;
   scanline_t scanline;
   scale_t    scale;
   logic      vcrop_en;
   // Set when the frame goes through the scandoubler
   logic      scandoubler;

   // Status register side
   modport src (
      output aspect, scanline, scale, vcrop_en, scandoubler
   );

   // Crop selector side
   modport dst (
      input aspect, scanline, scale, vcrop_en, scandoubler
   );

endinterface

// ==== video_status_reg.sv ====
// Byte-writable 64-bit host settings shadow with video field decode
module video_status_reg (
   input  logic                    CLK_VIDEO,
   input  logic                    arst_n,
   // Host byte write
   input  logic                    status_wr,
   input  logic [2:0]              status_addr,
   input  logic [7:0]              status_data,
   // Scandoubler forced by the host (VGA output)
   input  logic                    forced_scandoubler,
   video_cfg_if.src                cfg,
   output msx_video_pkg::scanline_t vga_sl
);
   import msx_video_pkg::*;

   // ==============================
   // Shadow register
   // ==============================

   // Full settings word, only the low byte is decoded here
   logic [63:0] status;
   // Byte lane offset of the current write
   logic [5:0]  lane_lsb;

   assign lane_lsb = {status_addr, 3'b000};

   // One byte lane per strobe
   always_ff @(posedge CLK_VIDEO or negedge arst_n) begin
      if (!arst_n) begin
         status <= '0;
      end else if (status_wr) begin
         status[lane_lsb +: 8] <= status_data;
      end
   end

   // ==============================
   // Field decode
   // ==============================

   // Decoded fields
   aspect_t   aspect;
   scanline_t scanline;
   scale_t    scale;
   logic      vcrop_en;

   // Plain decode, visible one cycle after the write
   assign aspect   = aspect_t'(status[ST_ASPECT +: 2]);
   assign scanline = scanline_t'(status[ST_SCANLINE +: 2]);
   assign scale    = scale_t'(status[ST_SCALE +: 2]);
   assign vcrop_en = status[ST_VCROP];

   // Onto the config interface
   assign cfg.aspect   = aspect;
   assign cfg.scanline = scanline;
   assign cfg.scale    = scale;
   assign cfg.vcrop_en = vcrop_en;

   // Any scanline effect needs the doubled frame
   assign cfg.scandoubler = forced_scandoubler || (scanline != SL_NONE);

   // Scanline level straight to the video output
   assign vga_sl = scanline;

endmodule

// ==== crop_select.sv ====
// Vertical crop, wide flag and aspect ratio selection from the HDMI output size
module crop_select (
   input  logic                                CLK_VIDEO,
   input  logic                                arst_n,
   video_cfg_if.dst                            cfg,
   // Reported HDMI mode
   input  logic [msx_video_pkg::HDMI_W-1:0]    hdmi_width,
   input  logic [msx_video_pkg::HDMI_W-1:0]    hdmi_height,
   // To the scaler
   output logic [msx_video_pkg::CROP_W-1:0]    crop_size,
   output logic [12:0]                         video_arx,
   output logic [12:0]                         video_ary,
   output msx_video_pkg::scale_t               scale
);
   import msx_video_pkg::*;

   // ==============================
   // Output shape
   // ==============================

   // Height plus half height, one bit wider to hold the carry
   logic [HDMI_W:0] h_span;
   // Width at least 1.5x height
   logic            is_wide;
   // Tall 4:3 modes that fail the wide test
   logic            is_tall43;

   assign h_span    = {1'b0, hdmi_height} + {2'b00, hdmi_height[HDMI_W-1:1]};
   assign is_wide   = {1'b0, hdmi_width} >= h_span;
   assign is_tall43 = !is_wide && (hdmi_width >= 12'd1440);

   // ==============================
   // Crop lookup
   // ==============================

   logic [CROP_W-1:0] crop_nxt;
   logic              wide_nxt;

   always_comb begin
      crop_nxt = '0;
      wide_nxt = 1'b0;
      // Doubled frames are never cropped
      if (!cfg.scandoubler && is_wide) begin
         case (hdmi_height)
            12'd480:  crop_nxt = 10'd240;
            12'd600: begin
               crop_nxt = 10'd200;
               wide_nxt = cfg.vcrop_en;
            end
            12'd720:  crop_nxt = 10'd240;
            // 256 lines, NTSC shows a few less
            12'd768:  crop_nxt = 10'd256;
            12'd800: begin
               crop_nxt = 10'd200;
               wide_nxt = cfg.vcrop_en;
            end
            12'd1080: crop_nxt = 10'd216;
            12'd1200: crop_nxt = 10'd240;
            default:  crop_nxt = '0;
         endcase
      end else if (!cfg.scandoubler && is_tall43) begin
         // 1920x1440 and 2048x1536
         case (hdmi_height)
            12'd1440: crop_nxt = 10'd240;
            12'd1536: crop_nxt = 10'd256;
            default:  crop_nxt = '0;
         endcase
      end
   end

   // ==============================
   // Aspect selection
   // ==============================

   logic [11:0] arx_nxt;
   logic [11:0] ary_nxt;

   always_comb begin
      if (cfg.aspect == ASPECT_ORIGINAL) begin
         // 200-line crop gets the narrower ratio
         arx_nxt = wide_nxt ? ARX_WIDE : ARX_NORMAL;
         ary_nxt = ARY_NORMAL;
      end else begin
         // Menu index of the scaler preset, ARY zero marks it
         arx_nxt = 12'(cfg.aspect) - 12'd1;
         ary_nxt = '0;
      end
   end

   // Single output stage
   always_ff @(posedge CLK_VIDEO or negedge arst_n) begin
      if (!arst_n) begin
         crop_size <= '0;
         video_arx <= {1'b0, ARX_NORMAL};
         video_ary <= {1'b0, ARY_NORMAL};
         scale     <= SCALE_NORMAL;
      end else begin
         crop_size <= cfg.vcrop_en ? crop_nxt : '0;
         // Bit 12 clear means ratio form
         video_arx <= {1'b0, arx_nxt};
         video_ary <= {1'b0, ary_nxt};
         scale     <= cfg.scale;
      end
   end

endmodule

// ==== gamma_lut.sv ====
// Per-channel gamma table pipeline with matched sync delay and bypass
module gamma_lut #(
   parameter int TABLE_DEPTH = 256
) (
   input  logic       CLK_VIDEO,
   input  logic       arst_n,
   // Table or raw pixel
   input  logic       gamma_en,
   // Table write port, addr is {channel, index}
   input  logic       gamma_wr,
   input  logic [9:0] gamma_addr,
   input  logic [7:0] gamma_data,
   // Pixel stream
   input  logic       ce_pixel,
   input  logic [7:0] r_in,
   input  logic [7:0] g_in,
   input  logic [7:0] b_in,
   input  logic       hs_in,
   input  logic       vs_in,
   input  logic       de_in,
   // To the video output
   output logic [7:0] vga_r,
   output logic [7:0] vga_g,
   output logic [7:0] vga_b,
   output logic       vga_hs,
   output logic       vga_vs,
   output logic       vga_de
);

   // Table index bits, taken from the top of each pixel
   localparam int IDX_W  = $clog2(TABLE_DEPTH);
   localparam int NUM_CH = 3;

   // ==============================
   // Write decode
   // ==============================

   logic [1:0]       wr_ch;
   logic [IDX_W-1:0] wr_idx;

   // Channel 3 has no table and matches no generate block
   assign wr_ch  = gamma_addr[9:8];
   assign wr_idx = gamma_addr[IDX_W-1:0];

   // R, G, B in channel order
   logic [7:0] pix_in [NUM_CH];

   assign pix_in[0] = r_in;
   assign pix_in[1] = g_in;
   assign pix_in[2] = b_in;

   // ==============================
   // Channel pipelines
   // ==============================

   for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
      // Gamma table for this channel
      logic [7:0]       table_mem [TABLE_DEPTH];
      // Stage 1 sample
      logic [7:0]       pix_q;
      logic [IDX_W-1:0] rd_idx;
      // Stage 2 result
      logic [7:0]       dout;

      assign rd_idx = pix_q[7 -: IDX_W];

      always_ff @(posedge CLK_VIDEO) begin
         if (gamma_wr && (wr_ch == 2'(ch))) begin
            table_mem[wr_idx] <= gamma_data;
         end
      end

      // Sample, then synchronous table read or raw pass
      always_ff @(posedge CLK_VIDEO) begin
         if (ce_pixel) begin
            pix_q <= pix_in[ch];
            dout  <= gamma_en ? table_mem[rd_idx] : pix_q;
         end
      end
   end

   assign vga_r = g_ch[0].dout;
   assign vga_g = g_ch[1].dout;
   assign vga_b = g_ch[2].dout;

   // ==============================
   // Sync delay
   // ==============================

   // {hs, vs, de}, same two CE stages as the pixel
   logic [2:0] sync_q;
   logic [2:0] sync_out;

   always_ff @(posedge CLK_VIDEO or negedge arst_n) begin
      if (!arst_n) begin
         sync_q   <= '0;
         sync_out <= '0;
      end else if (ce_pixel) begin
         sync_q   <= {hs_in, vs_in, de_in};
         sync_out <= sync_q;
      end
   end

   assign vga_hs = sync_out[2];
   assign vga_vs = sync_out[1];
   assign vga_de = sync_out[0];

endmodule

// ==== msx_video.sv ====
// Video output stage top: status shadow, crop and aspect selection, gamma tables
module msx_video #(
   parameter int TABLE_DEPTH = 256
) (
   input  logic                             CLK_VIDEO,
   input  logic                             arst_n,
   // Host status write
   input  logic                             status_wr,
   input  logic [2:0]                       status_addr,
   input  logic [7:0]                       status_data,
   // HDMI mode and host flags
   input  logic [msx_video_pkg::HDMI_W-1:0] hdmi_width,
   input  logic [msx_video_pkg::HDMI_W-1:0] hdmi_height,
   input  logic                             forced_scandoubler,
   // Gamma table control
   input  logic                             gamma_en,
   input  logic                             gamma_wr,
   input  logic [9:0]                       gamma_addr,
   input  logic [7:0]                       gamma_data,
   // Pixel input
   input  logic                             ce_pixel,
   input  logic [7:0]                       r_in,
   input  logic [7:0]                       g_in,
   input  logic [7:0]                       b_in,
   input  logic                             hs_in,
   input  logic                             vs_in,
   input  logic                             de_in,
   // Video out
   output logic [7:0]                       vga_r,
   output logic [7:0]                       vga_g,
   output logic [7:0]                       vga_b,
   output logic                             vga_hs,
   output logic                             vga_vs,
   output logic                             vga_de,
   output msx_video_pkg::scanline_t         vga_sl,
   // Scaler control
   output logic [12:0]                      video_arx,
   output logic [12:0]                      video_ary,
   output logic [msx_video_pkg::CROP_W-1:0] crop_size,
   output msx_video_pkg::scale_t            scale
);

   // Decoded settings
   video_cfg_if cfg_if ();

   video_status_reg u_status (
      .CLK_VIDEO          (CLK_VIDEO),
      .arst_n             (arst_n),
      .status_wr          (status_wr),
      .status_addr        (status_addr),
      .status_data        (status_data),
      .forced_scandoubler (forced_scandoubler),
      .cfg                (cfg_if.src),
      .vga_sl             (vga_sl)
   );

   crop_select u_crop (
      .CLK_VIDEO   (CLK_VIDEO),
      .arst_n      (arst_n),
      .cfg         (cfg_if.dst),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .crop_size   (crop_size),
      .video_arx   (video_arx),
      .video_ary   (video_ary),
      .scale       (scale)
   );

   // Pixel path, independent of the status word
   gamma_lut #(
      .TABLE_DEPTH (TABLE_DEPTH)
   ) u_gamma (
      .CLK_VIDEO  (CLK_VIDEO),
      .arst_n     (arst_n),
      .gamma_en   (gamma_en),
      .gamma_wr   (gamma_wr),
      .gamma_addr (gamma_addr),
      .gamma_data (gamma_data),
      .ce_pixel   (ce_pixel),
      .r_in       (r_in),
      .g_in       (g_in),
      .b_in       (b_in),
      .hs_in      (hs_in),
      .vs_in      (vs_in),
      .de_in      (de_in),
      .vga_r      (vga_r),
      .vga_g      (vga_g),
      .vga_b      (vga_b),
      .vga_hs     (vga_hs),
      .vga_vs     (vga_vs),
      .vga_de     (vga_de)
   );

endmodule

// ==== msx_video_assert.sv ====
// Concurrent checks on the sync, crop and aspect outputs of the video stage
module msx_video_assert (
   input logic                             CLK_VIDEO,
   input logic                             arst_n,
   input logic                             vga_de,
   input logic [msx_video_pkg::CROP_W-1:0] crop_size,
   input logic [12:0]                      video_ary,
   // Decoded settings from the config interface
   input logic                             vcrop_en,
   input msx_video_pkg::aspect_t           aspect
);
   import msx_video_pkg::*;

   // ==============================
   // Reset behavior
   // ==============================

   // Sync delay line held clear by the async reset
   property p_de_low_in_reset;
      @(posedge CLK_VIDEO) !arst_n |-> !vga_de;
   endproperty

   a_de_low_in_reset : assert property (p_de_low_in_reset)
      else $error("vga_de high while reset is held");

   // ==============================
   // Crop and aspect outputs
   // ==============================

   // Crop gated by vcrop_en, one register stage
   property p_crop_off;
      @(posedge CLK_VIDEO) disable iff (!arst_n)
         !vcrop_en |=> (crop_size == '0);
   endproperty

   // Preset aspect modes always carry ARY of zero
   property p_ary_preset;
      @(posedge CLK_VIDEO) disable iff (!arst_n)
         (aspect != ASPECT_ORIGINAL) |=> (video_ary == '0);
   endproperty

   a_crop_off : assert property (p_crop_off)
      else $error("crop_size nonzero after vcrop_en was clear");

   a_ary_preset : assert property (p_ary_preset)
      else $error("video_ary nonzero for a preset aspect");

endmodule

bind msx_video msx_video_assert u_video_assert (
   .CLK_VIDEO (CLK_VIDEO),
   .arst_n    (arst_n),
   .vga_de    (vga_de),
   .crop_size (crop_size),
   .video_ary (video_ary),
   .vcrop_en  (cfg_if.vcrop_en),
   .aspect    (cfg_if.aspect)
);

// ==== msx_video_tb.sv ====
// Video output stage testbench covering status decode, crop and aspect rules and the gamma pipeline
module msx_video_tb;
   import msx_video_pkg::*;

   // ==============================
   // DUT signals
   // ==============================

   logic              CLK_VIDEO;
   logic              arst_n;
   logic              status_wr;
   logic [2:0]        status_addr;
   logic [7:0]        status_data;
   logic [HDMI_W-1:0] hdmi_width;
   logic [HDMI_W-1:0] hdmi_height;
   logic              forced_scandoubler;
   logic              gamma_en;
   logic              gamma_wr;
   logic [9:0]        gamma_addr;
   logic [7:0]        gamma_data;
   logic              ce_pixel;
   logic [7:0]        r_in;
   logic [7:0]        g_in;
   logic [7:0]        b_in;
   logic              hs_in;
   logic              vs_in;
   logic              de_in;
   logic [7:0]        vga_r;
   logic [7:0]        vga_g;
   logic [7:0]        vga_b;
   logic              vga_hs;
   logic              vga_vs;
   logic              vga_de;
   logic [1:0]        vga_sl;
   logic [12:0]       video_arx;
   logic [12:0]       video_ary;
   logic [CROP_W-1:0] crop_size;
   logic [1:0]        scale;

   msx_video #(
      .TABLE_DEPTH (256)
   ) u_msx_video (
      .CLK_VIDEO          (CLK_VIDEO),
      .arst_n             (arst_n),
      .status_wr          (status_wr),
      .status_addr        (status_addr),
      .status_data        (status_data),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .forced_scandoubler (forced_scandoubler),
      .gamma_en           (gamma_en),
      .gamma_wr           (gamma_wr),
      .gamma_addr         (gamma_addr),
      .gamma_data         (gamma_data),
      .ce_pixel           (ce_pixel),
      .r_in               (r_in),
      .g_in               (g_in),
      .b_in               (b_in),
      .hs_in              (hs_in),
      .vs_in              (vs_in),
      .de_in              (de_in),
      .vga_r              (vga_r),
      .vga_g              (vga_g),
      .vga_b              (vga_b),
      .vga_hs             (vga_hs),
      .vga_vs             (vga_vs),
      .vga_de             (vga_de),
      .vga_sl             (vga_sl),
      .video_arx          (video_arx),
      .video_ary          (video_ary),
      .crop_size          (crop_size),
      .scale              (scale)
   );

   // ==============================
   // Stimulus table
   // ==============================

   // One status write plus HDMI mode and the expected scaler outputs
   typedef struct packed {
      logic [2:0]  addr;
      logic [7:0]  data;
      logic [11:0] width;
      logic [11:0] height;
      logic        fsd;
      logic [9:0]  crop;
      logic [12:0] arx;
      logic [12:0] ary;
      logic [1:0]  scale;
      logic [1:0]  sl;
   } row_t;

   row_t        rows [$];
   logic [31:0] lfsr_state;

   function automatic row_t make_row(input int addr, input int data, input int width,
                                     input int height, input int fsd, input int crop,
                                     input int arx, input int ary, input int scl,
                                     input int sl);
      row_t r;
      r.addr   = 3'(addr);
      r.data   = 8'(data);
      r.width  = 12'(width);
      r.height = 12'(height);
      r.fsd    = 1'(fsd);
      r.crop   = 10'(crop);
      r.arx    = 13'(arx);
      r.ary    = 13'(ary);
      r.scale  = 2'(scl);
      r.sl     = 2'(sl);
      return r;
   endfunction

   // Status byte 0 is {vcrop, scale, scanline, aspect, unused}
   task automatic build_rows();
      // addr, data, width, height, fsd, crop, arx, ary, scale, sl
      rows.push_back(make_row(0, 'h80,  720,  480, 0, 240, 400, 300, 0, 0));
      rows.push_back(make_row(0, 'ha0, 1024,  600, 0, 200, 340, 300, 1, 0));
      rows.push_back(make_row(0, 'hc0, 1280,  720, 0, 240, 400, 300, 2, 0));
      rows.push_back(make_row(0, 'he0, 1366,  768, 0, 256, 400, 300, 3, 0));
      rows.push_back(make_row(0, 'h80, 1280,  800, 0, 200, 340, 300, 0, 0));
      rows.push_back(make_row(0, 'h80, 1920, 1080, 0, 216, 400, 300, 0, 0));
      rows.push_back(make_row(0, 'h80, 1920, 1200, 0, 240, 400, 300, 0, 0));
      // Tall 4:3 modes
      rows.push_back(make_row(0, 'h80, 1920, 1440, 0, 240, 400, 300, 0, 0));
      rows.push_back(make_row(0, 'h80, 2048, 1536, 0, 256, 400, 300, 0, 0));
      // Neither wide nor tall
      rows.push_back(make_row(0, 'h80,  640,  480, 0,   0, 400, 300, 0, 0));
      // Crop killed by scandoubler or vcrop off
      rows.push_back(make_row(0, 'h80, 1920, 1440, 1,   0, 400, 300, 0, 0));
      rows.push_back(make_row(0, 'h00, 1024,  600, 0,   0, 400, 300, 0, 0));
      rows.push_back(make_row(0, 'h80, 1024,  600, 1,   0, 400, 300, 0, 0));
      rows.push_back(make_row(0, 'h90, 1024,  600, 0,   0, 400, 300, 0, 2));
      rows.push_back(make_row(0, 'hb8, 1280,  800, 0,   0, 400, 300, 1, 3));
      // Other byte lanes leave the fields alone
      rows.push_back(make_row(3, 'hff, 1280,  800, 0,   0, 400, 300, 1, 3));
      // Preset aspect modes
      rows.push_back(make_row(0, 'h82, 1280,  720, 0, 240,   0,   0, 0, 0));
      rows.push_back(make_row(0, 'h84, 1280,  720, 0, 240,   1,   0, 0, 0));
      rows.push_back(make_row(0, 'h86, 1280,  800, 0, 200,   2,   0, 0, 0));
      rows.push_back(make_row(5, 'h55, 1280,  800, 0, 200,   2,   0, 0, 0));
      rows.push_back(make_row(0, 'h06, 1280,  800, 0,   0,   2,   0, 0, 0));
      rows.push_back(make_row(0, 'h80, 1280,  800, 0, 200, 340, 300, 0, 0));
   endtask

   // ==============================
   // Helpers
   // ==============================

   // Galois LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   task automatic draw_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at time %0t: %s, got %0d, expected %0d",
                  $time, what, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "Value mismatch");
      end
   endtask

   // Gamma table content is index XOR this per channel
   function automatic logic [7:0] table_key(input int ch);
      case (ch)
         0: return 8'h5a;
         1: return 8'h3c;
         2: return 8'hc3;
         // Channel 3 writes junk that must not land
         default: return 8'hff;
      endcase
   endfunction

   // Write and wait two clocks for the crop registers
   task automatic apply_row(input row_t r, input int idx);
      hdmi_width         = r.width;
      hdmi_height        = r.height;
      forced_scandoubler = r.fsd;
      status_wr          = 1'b1;
      status_addr        = r.addr;
      status_data        = r.data;
      @(negedge CLK_VIDEO);
      status_wr = 1'b0;
      @(negedge CLK_VIDEO);
      check_equal(32'(crop_size), 32'(r.crop), $sformatf("row %0d crop_size", idx));
      check_equal(32'(video_arx), 32'(r.arx), $sformatf("row %0d video_arx", idx));
      check_equal(32'(video_ary), 32'(r.ary), $sformatf("row %0d video_ary", idx));
      check_equal(32'(scale), 32'(r.scale), $sformatf("row %0d scale", idx));
      check_equal(32'(vga_sl), 32'(r.sl), $sformatf("row %0d vga_sl", idx));
   endtask

   task automatic load_gamma();
      for (int ch = 0; ch < 4; ch++) begin
         for (int i = 0; i < 256; i++) begin
            gamma_wr   = 1'b1;
            gamma_addr = {2'(ch), 8'(i)};
            gamma_data = 8'(i) ^ table_key(ch);
            @(negedge CLK_VIDEO);
         end
      end
      gamma_wr = 1'b0;
   endtask

   // Random pixels on a random CE pattern with outputs checked two CE edges later
   task automatic run_pixels(input int count, input logic use_table);
      logic [31:0] bits;
      logic [26:0] sent [$];
      logic [26:0] word;
      logic [7:0]  exp_r;
      logic [7:0]  exp_g;
      logic [7:0]  exp_b;
      int          cycles;
      int          seen;
      cycles   = 0;
      seen     = 0;
      gamma_en = use_table;
      while (seen < count) begin
         if (cycles >= count * 8) begin
            $display("Timeout: too few ce_pixel cycles in the pixel test");
            $display("STATUS: FAIL");
            $fatal(1, "Pixel test timeout");
         end
         if (seen >= 2) begin
            word  = sent[seen - 2];
            exp_r = word[26:19];
            exp_g = word[18:11];
            exp_b = word[10:3];
            if (use_table) begin
               exp_r = exp_r ^ table_key(0);
               exp_g = exp_g ^ table_key(1);
               exp_b = exp_b ^ table_key(2);
            end
            check_equal(32'(vga_r), 32'(exp_r), $sformatf("pixel %0d vga_r", seen - 2));
            check_equal(32'(vga_g), 32'(exp_g), $sformatf("pixel %0d vga_g", seen - 2));
            check_equal(32'(vga_b), 32'(exp_b), $sformatf("pixel %0d vga_b", seen - 2));
            check_equal(32'({vga_hs, vga_vs, vga_de}), 32'(word[2:0]),
                        $sformatf("pixel %0d syncs", seen - 2));
         end
         draw_bits(1, bits);
         ce_pixel = bits[0];
         draw_bits(27, bits);
         {r_in, g_in, b_in, hs_in, vs_in, de_in} = bits[26:0];
         if (ce_pixel) begin
            sent.push_back(bits[26:0]);
            seen++;
         end
         cycles++;
         @(negedge CLK_VIDEO);
      end
      ce_pixel = 1'b0;
   endtask

   // ==============================
   // Clock and main sequence
   // ==============================

   initial begin
      CLK_VIDEO = 1'b0;
      forever #5 CLK_VIDEO = ~CLK_VIDEO;
   end

   initial begin
      arst_n             = 1'b1;
      status_wr          = 1'b0;
      status_addr        = '0;
      status_data        = '0;
      hdmi_width         = '0;
      hdmi_height        = '0;
      forced_scandoubler = 1'b0;
      gamma_en           = 1'b0;
      gamma_wr           = 1'b0;
      gamma_addr         = '0;
      gamma_data         = '0;
      ce_pixel           = 1'b0;
      r_in               = '0;
      g_in               = '0;
      b_in               = '0;
      hs_in              = 1'b0;
      vs_in              = 1'b0;
      de_in              = 1'b0;
      lfsr_state         = 32'h51ee;
      build_rows();

      // Reset edge before the first rising clock
      #1;
      arst_n = 1'b0;
      repeat (5) @(negedge CLK_VIDEO);

      // Reset values seen while reset is still held
      check_equal(32'(crop_size), 0, "crop_size during reset");
      check_equal(32'(video_arx), 400, "video_arx during reset");
      check_equal(32'(video_ary), 300, "video_ary during reset");
      check_equal(32'(vga_sl), 0, "vga_sl during reset");
      check_equal(32'(vga_de), 0, "vga_de during reset");
      arst_n = 1'b1;
      @(negedge CLK_VIDEO);

      // Reset state
      check_equal(32'(crop_size), 0, "crop_size after reset");
      check_equal(32'(video_arx), 400, "video_arx after reset");
      check_equal(32'(video_ary), 300, "video_ary after reset");
      check_equal(32'(vga_sl), 0, "vga_sl after reset");
      check_equal(32'(vga_de), 0, "vga_de after reset");

      foreach (rows[i]) begin
         apply_row(rows[i], i);
      end

      // Bypass runs first while the tables are still unwritten
      run_pixels(200, 1'b0);
      load_gamma();
      run_pixels(200, 1'b1);

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== msx_video.f ====
msx_video_pkg.sv
video_cfg_if.sv
video_status_reg.sv
crop_select.sv
gamma_lut.sv
msx_video.sv
msx_video_assert.sv
msx_video_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the msx_video testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module msx_video_tb \
   -f msx_video.f \
   --Mdir obj_dir -o msx_video_sim

./obj_dir/msx_video_sim
